/* common/riscv_config.svh */
//////////////////////////////////////////////////
// Fixed by the RV32I subset. Changing these does
// not resize opcode fields or the instruction word
//////////////////////////////////////////////////

`ifndef RISCV_CONFIG_SVH
`define RISCV_CONFIG_SVH

// Integer register and datapath width
`define RV_XLEN     32

// Architectural registers, x0 hardwired to zero
`define RV_REG_CNT  32

// First fetch address after reset
`define RV_PC_INIT  32'h0000_0200

`endif

/* common/riscv_pkg.sv */
//////////////////////////////////////////////////
// RV32I subset encodings and decode views only
//////////////////////////////////////////////////

`default_nettype none

package riscv_pkg;

  // Major opcodes, instr[6:0]
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_jal    = 7'b1101111;

  // ALU operations selected in decode
  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASS_B
  } alu_op_t;

  //////////////////////////////////////////////////
  // Instruction formats, MSB first
  //////////////////////////////////////////////////
  typedef struct packed {
    logic [6:0] funct7; logic [4:0] rs2; logic [4:0] rs1;
    logic [2:0] funct3; logic [4:0] rd;  logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm; logic [4:0] rs1; logic [2:0] funct3;
    logic [4:0]  rd;  logic [6:0] opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm11_5; logic [4:0] rs2; logic [4:0] rs1;
    logic [2:0] funct3;  logic [4:0] imm4_0; logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic imm12; logic [5:0] imm10_5; logic [4:0] rs2; logic [4:0] rs1;
    logic [2:0] funct3; logic [3:0] imm4_1; logic imm11; logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm31_12; logic [4:0] rd; logic [6:0] opcode;
  } u_fmt_t;

  typedef struct packed {
    logic imm20; logic [9:0] imm10_1; logic imm11; logic [7:0] imm19_12;
    logic [4:0] rd; logic [6:0] opcode;
  } j_fmt_t;

  // Same 32-bit word, read per format
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } instr_t;

endpackage

`default_nettype wire

/* hw/decode/riscv_id.sv */
//////////////////////////////////////////////////
// Unsupported encodings decode with id_we low
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none
`include "riscv_config.svh"

module riscv_id (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic                id_load,
  input  wire logic [31:0]         if_parcel,
  input  wire logic [`RV_XLEN-1:0] if_pc,
  input  wire logic [`RV_XLEN-1:0] rf_srcv1,
  input  wire logic [`RV_XLEN-1:0] rf_srcv2,
  output      logic                id_valid,
  output      logic [`RV_XLEN-1:0] id_pc,
  output      riscv_pkg::instr_t   id_instr,
  output      logic [4:0]          rf_src1,
  output      logic [4:0]          rf_src2,
  output      logic [`RV_XLEN-1:0] id_opa,
  output      logic [`RV_XLEN-1:0] id_opb,
  output      logic [`RV_XLEN-1:0] id_imm,
  output      riscv_pkg::alu_op_t  id_alu_op,
  output      logic [4:0]          id_dst,
  output      logic                id_we
);

  logic use_imm;

  // Valid strobe one cycle after the parcel
  always_ff @(posedge clk)
  begin
    if (rst)
      id_valid <= 1'b0;
    else
      id_valid <= id_load;
  end

  // Instruction and its PC
  always_ff @(posedge clk)
  begin
    if (id_load)
    begin
      id_instr <= if_parcel;
      id_pc    <= if_pc;
    end
  end

  //////////////////////////////////////////////////
  // Field decode
  //////////////////////////////////////////////////
  always_comb
  begin
    id_imm    = '0;
    id_alu_op = riscv_pkg::ALU_ADD;
    id_we     = 1'b0;
    use_imm   = 1'b0;
    case (id_instr.r.opcode)
      riscv_pkg::opc_op:
      begin
        id_we = 1'b1;
        case (id_instr.r.funct3)
          3'b000: id_alu_op = id_instr.r.funct7[5] ? riscv_pkg::ALU_SUB : riscv_pkg::ALU_ADD;
          3'b010: id_alu_op = riscv_pkg::ALU_SLT;
          3'b100: id_alu_op = riscv_pkg::ALU_XOR;
          3'b110: id_alu_op = riscv_pkg::ALU_OR;
          3'b111: id_alu_op = riscv_pkg::ALU_AND;
          default: id_we = 1'b0;
        endcase
        // funct7 0x20 only for SUB
        if (id_instr.r.funct7 != 7'h00 &&
            !(id_instr.r.funct7 == 7'h20 && id_instr.r.funct3 == 3'b000))
          id_we = 1'b0;
      end
      riscv_pkg::opc_op_imm:
      begin
        use_imm = 1'b1;
        id_imm  = {{20{id_instr.i.imm[11]}}, id_instr.i.imm};
        id_we   = 1'b1;
        case (id_instr.i.funct3)
          3'b000: id_alu_op = riscv_pkg::ALU_ADD;
          3'b100: id_alu_op = riscv_pkg::ALU_XOR;
          3'b110: id_alu_op = riscv_pkg::ALU_OR;
          3'b111: id_alu_op = riscv_pkg::ALU_AND;
          default: id_we = 1'b0;
        endcase
      end
      riscv_pkg::opc_lui:
      begin
        use_imm   = 1'b1;
        id_imm    = {id_instr.u.imm31_12, 12'h000};
        id_alu_op = riscv_pkg::ALU_PASS_B;
        id_we     = 1'b1;
      end
      riscv_pkg::opc_load:
      begin
        // LW only
        use_imm = 1'b1;
        id_imm  = {{20{id_instr.i.imm[11]}}, id_instr.i.imm};
        id_we   = (id_instr.i.funct3 == 3'b010);
      end
      // Store keeps rs2 on B as write data
      riscv_pkg::opc_store:
        id_imm = {{20{id_instr.s.imm11_5[6]}}, id_instr.s.imm11_5, id_instr.s.imm4_0};
      riscv_pkg::opc_jal:
        id_we = 1'b1;
      default: ;
    endcase
  end

  // Register read and operand select
  assign rf_src1 = id_instr.r.rs1;
  assign rf_src2 = id_instr.r.rs2;
  assign id_dst  = id_instr.r.rd;
  assign id_opa  = rf_srcv1;
  assign id_opb  = use_imm ? id_imm : rf_srcv2;

endmodule

`default_nettype wire

/* hw/decode/riscv_rf.sv */
//////////////////////////////////////////////////
// No reset on contents. x0 always reads zero
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none
`include "riscv_config.svh"

module riscv_rf (
  input  wire logic                          clk,
  input  wire logic [$clog2(`RV_REG_CNT)-1:0] rf_src1,
  input  wire logic [$clog2(`RV_REG_CNT)-1:0] rf_src2,
  input  wire logic [$clog2(`RV_REG_CNT)-1:0] dbg_addr,
  input  wire logic [$clog2(`RV_REG_CNT)-1:0] rf_dst,
  input  wire logic [`RV_XLEN-1:0]           rf_dstv,
  input  wire logic                          rf_we,
  output      logic [`RV_XLEN-1:0]           rf_srcv1,
  output      logic [`RV_XLEN-1:0]           rf_srcv2,
  output      logic [`RV_XLEN-1:0]           dbg_dato
);

  logic [`RV_XLEN-1:0] regs [`RV_REG_CNT];

  // Single write port, x0 writes dropped
  always_ff @(posedge clk)
  begin
    if (rf_we && (rf_dst != '0))
      regs[rf_dst] <= rf_dstv;
  end

  // Operand reads
  assign rf_srcv1 = (rf_src1 == '0) ? '0 : regs[rf_src1];
  assign rf_srcv2 = (rf_src2 == '0) ? '0 : regs[rf_src2];

  // Debug read, same rule for x0
  assign dbg_dato = (dbg_addr == '0) ? '0 : regs[dbg_addr];

  // Write-back must present a known destination
  a_dst_known: assert property (@(posedge clk) rf_we |-> !$isunknown(rf_dst));

endmodule

`default_nettype wire

/* hw/execute/riscv_alu.sv */
//////////////////////////////////////////////////
// Purely combinational. SLT is signed only
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none
`include "riscv_config.svh"

module riscv_alu (
  input  wire logic [`RV_XLEN-1:0] id_opa,
  input  wire logic [`RV_XLEN-1:0] id_opb,
  input  wire riscv_pkg::alu_op_t  id_alu_op,
  input  wire logic [`RV_XLEN-1:0] id_imm,
  output      logic [`RV_XLEN-1:0] ex_r,
  output      logic [`RV_XLEN-1:0] ex_memadr
);

  //////////////////////////////////////////////////
  // Result
  //////////////////////////////////////////////////
  always_comb
  begin
    case (id_alu_op)
      riscv_pkg::ALU_ADD:    ex_r = id_opa + id_opb;
      riscv_pkg::ALU_SUB:    ex_r = id_opa - id_opb;
      riscv_pkg::ALU_AND:    ex_r = id_opa & id_opb;
      riscv_pkg::ALU_OR:     ex_r = id_opa | id_opb;
      riscv_pkg::ALU_XOR:    ex_r = id_opa ^ id_opb;
      // Signed compare, zero-extended flag
      riscv_pkg::ALU_SLT:
        ex_r = {{(`RV_XLEN-1){1'b0}}, $signed(id_opa) < $signed(id_opb)};
      // LUI passes the shifted immediate
      riscv_pkg::ALU_PASS_B: ex_r = id_opb;
      default:               ex_r = id_opa + id_opb;
    endcase
  end

  //////////////////////////////////////////////////
  // Load/store address
  //////////////////////////////////////////////////
  // Own adder, so opb stays free for store data
  assign ex_memadr = id_opa + id_imm;

endmodule

`default_nettype wire

/* hw/execute/riscv_bu.sv */
//////////////////////////////////////////////////
// BEQ, BNE and JAL only. No prediction
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none
`include "riscv_config.svh"

module riscv_bu (
  input  wire riscv_pkg::instr_t   id_instr,
  input  wire logic [`RV_XLEN-1:0] id_pc,
  input  wire logic [`RV_XLEN-1:0] id_opa,
  input  wire logic [`RV_XLEN-1:0] id_opb,
  output      logic                bu_taken,
  output      logic [`RV_XLEN-1:0] bu_target
);

  logic [`RV_XLEN-1:0] b_imm;
  logic [`RV_XLEN-1:0] j_imm;
  logic                is_branch;
  logic                is_jal;

  // PC-relative offsets, bit 0 always zero
  assign b_imm = {{20{id_instr.b.imm12}}, id_instr.b.imm11, id_instr.b.imm10_5,
                  id_instr.b.imm4_1, 1'b0};
  assign j_imm = {{12{id_instr.j.imm20}}, id_instr.j.imm19_12, id_instr.j.imm11,
                  id_instr.j.imm10_1, 1'b0};

  assign is_branch = (id_instr.b.opcode == riscv_pkg::opc_branch);
  assign is_jal    = (id_instr.j.opcode == riscv_pkg::opc_jal);

  // funct3 000 is BEQ, 001 is BNE, rest never taken
  assign bu_taken  = is_jal ||
                     (is_branch && id_instr.b.funct3 == 3'b000 && id_opa == id_opb) ||
                     (is_branch && id_instr.b.funct3 == 3'b001 && id_opa != id_opb);

  assign bu_target = id_pc + (is_jal ? j_imm : b_imm);

endmodule

`default_nettype wire

/* hw/fetch/riscv_if.sv */
//////////////////////////////////////////////////
// One instruction in flight. A new fetch starts
// only after retirement, and not under dbg_stall
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none
`include "riscv_config.svh"

module riscv_if (
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic               if_parcel_valid,
  input  wire logic               wb_done,
  input  wire logic [`RV_XLEN-1:0] wb_nxt_pc,
  input  wire logic               dbg_stall,
  output      logic [`RV_XLEN-1:0] if_nxt_pc,
  output      logic               if_req,
  output      logic               id_load,
  output      logic [`RV_XLEN-1:0] if_pc
);

  // Sequencer states
  localparam logic [1:0] S_REQ         = 2'd0;
  localparam logic [1:0] S_WAIT_PARCEL = 2'd1;
  localparam logic [1:0] S_WAIT_RETIRE = 2'd2;

  logic [1:0]          state;
  logic [`RV_XLEN-1:0] pc;

  //////////////////////////////////////////////////
  // PC and request sequencing
  //////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state  <= S_REQ;
      if_req <= 1'b0;
      pc     <= `RV_PC_INIT;
    end
    else
    begin
      // Request is a single-cycle strobe
      if_req <= 1'b0;
      case (state)
        S_REQ:
          if (!dbg_stall)
          begin
            if_req <= 1'b1;
            state  <= S_WAIT_PARCEL;
          end
        S_WAIT_PARCEL:
          if (if_parcel_valid)
            state <= S_WAIT_RETIRE;
        default:
          if (wb_done)
          begin
            pc <= wb_nxt_pc;
            // Stall parks in S_REQ until released
            if (dbg_stall)
              state <= S_REQ;
            else
            begin
              if_req <= 1'b1;
              state  <= S_WAIT_PARCEL;
            end
          end
      endcase
    end
  end

  // Address held from request to parcel
  assign if_nxt_pc = pc;
  assign if_pc     = pc;
  assign id_load   = if_parcel_valid && (state == S_WAIT_PARCEL);

  // Memory must not return a parcel that was never requested
  a_parcel_when_waiting: assert property (
    @(posedge clk) disable iff (rst) if_parcel_valid |-> state == S_WAIT_PARCEL);

endmodule

`default_nettype wire

/* hw/riscv_core.sv */
//////////////////////////////////////////////////
// Non-pipelined RV32I subset. Debug port is
// register read plus fetch stall only
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none
`include "riscv_config.svh"

module riscv_core (
  input  wire logic                clk,
  input  wire logic                rst,

  // Instruction fetch bus
  output      logic [`RV_XLEN-1:0] if_nxt_pc,
  output      logic                if_req,
  input  wire logic [31:0]         if_parcel,
  input  wire logic                if_parcel_valid,

  // Data memory bus
  output      logic [`RV_XLEN-1:0] dmem_adr,
  output      logic [`RV_XLEN-1:0] dmem_d,
  input  wire logic [`RV_XLEN-1:0] dmem_q,
  output      logic                dmem_we,
  output      logic                dmem_req,
  input  wire logic                dmem_ack,

  // Debug
  input  wire logic                dbg_stall,
  input  wire logic [4:0]          dbg_addr,
  output      logic [`RV_XLEN-1:0] dbg_dato
);

  //////////////////////////////////////////////////
  // Inter-unit wires
  //////////////////////////////////////////////////
  // Fetch to decode
  logic                id_load;
  logic [`RV_XLEN-1:0] if_pc;

  // Decode outputs
  logic                id_valid;
  logic                id_we;
  logic [`RV_XLEN-1:0] id_pc;
  logic [`RV_XLEN-1:0] id_opa;
  logic [`RV_XLEN-1:0] id_opb;
  logic [`RV_XLEN-1:0] id_imm;
  logic [4:0]          id_dst;
  riscv_pkg::instr_t   id_instr;
  riscv_pkg::alu_op_t  id_alu_op;

  // Register file ports
  logic [4:0]          rf_src1;
  logic [4:0]          rf_src2;
  logic [4:0]          rf_dst;
  logic [`RV_XLEN-1:0] rf_srcv1;
  logic [`RV_XLEN-1:0] rf_srcv2;
  logic [`RV_XLEN-1:0] rf_dstv;
  logic                rf_we;

  // Execute results
  logic [`RV_XLEN-1:0] ex_r;
  logic [`RV_XLEN-1:0] ex_memadr;
  logic                bu_taken;
  logic [`RV_XLEN-1:0] bu_target;

  // Retirement back to fetch
  logic                wb_done;
  logic [`RV_XLEN-1:0] wb_nxt_pc;

  //////////////////////////////////////////////////
  // Units
  //////////////////////////////////////////////////
  riscv_if  if_unit  (.*);
  riscv_id  id_unit  (.*);
  riscv_rf  int_rf   (.*);

  // ALU and branch unit side by side
  riscv_alu alu_unit (.*);
  riscv_bu  bu_unit  (.*);

  // Combines both, owns the data bus
  riscv_wb  wb_unit  (.*);

endmodule

`default_nettype wire

/* hw/riscv_wb.sv */
//////////////////////////////////////////////////
// Word access only. dmem signals held until ack
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none
`include "riscv_config.svh"

module riscv_wb (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic                id_valid,
  input  wire riscv_pkg::instr_t   id_instr,
  input  wire logic [`RV_XLEN-1:0] id_pc,
  input  wire logic [4:0]          id_dst,
  input  wire logic                id_we,
  input  wire logic [`RV_XLEN-1:0] id_opb,
  input  wire logic [`RV_XLEN-1:0] ex_r,
  input  wire logic [`RV_XLEN-1:0] ex_memadr,
  input  wire logic                bu_taken,
  input  wire logic [`RV_XLEN-1:0] bu_target,
  input  wire logic [`RV_XLEN-1:0] dmem_q,
  input  wire logic                dmem_ack,
  output      logic [`RV_XLEN-1:0] dmem_adr,
  output      logic [`RV_XLEN-1:0] dmem_d,
  output      logic                dmem_we,
  output      logic                dmem_req,
  output      logic [4:0]          rf_dst,
  output      logic [`RV_XLEN-1:0] rf_dstv,
  output      logic                rf_we,
  output      logic                wb_done,
  output      logic [`RV_XLEN-1:0] wb_nxt_pc
);

  logic                is_lw;
  logic                is_sw;
  logic [`RV_XLEN-1:0] pc_plus4;

  assign is_lw    = (id_instr.i.opcode == riscv_pkg::opc_load) &&
                    (id_instr.i.funct3 == 3'b010);
  assign is_sw    = (id_instr.s.opcode == riscv_pkg::opc_store) &&
                    (id_instr.s.funct3 == 3'b010);
  assign pc_plus4 = id_pc + 'd4;

  //////////////////////////////////////////////////
  // Retire and memory request control
  //////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      dmem_req <= 1'b0;
      dmem_we  <= 1'b0;
      rf_we    <= 1'b0;
      wb_done  <= 1'b0;
    end
    else
    begin
      rf_we   <= 1'b0;
      wb_done <= 1'b0;
      if (dmem_req)
      begin
        // Hold under back-pressure until ack
        if (dmem_ack)
        begin
          dmem_req <= 1'b0;
          dmem_we  <= 1'b0;
          // Only loads write the register
          rf_we    <= ~dmem_we;
          wb_done  <= 1'b1;
        end
      end
      else if (id_valid)
      begin
        if (is_lw || is_sw)
        begin
          dmem_req <= 1'b1;
          dmem_we  <= is_sw;
        end
        else
        begin
          rf_we   <= id_we;
          wb_done <= 1'b1;
        end
      end
    end
  end

  // Payload captured in the decode cycle
  always_ff @(posedge clk)
  begin
    if (id_valid)
    begin
      rf_dst    <= id_dst;
      // JAL links PC+4
      rf_dstv   <= (id_instr.j.opcode == riscv_pkg::opc_jal) ? pc_plus4 : ex_r;
      wb_nxt_pc <= bu_taken ? bu_target : pc_plus4;
      dmem_adr  <= ex_memadr;
      dmem_d    <= id_opb;
    end
    else if (dmem_req && dmem_ack)
      rf_dstv <= dmem_q;
  end

  // Request and its payload held until the memory acks
  a_req_until_ack: assert property (
    @(posedge clk) disable iff (rst)
      dmem_req && !dmem_ack |=> dmem_req && $stable(dmem_adr) && $stable(dmem_d));

endmodule

`default_nettype wire

/* riscv_core.f */
+incdir+common
common/riscv_pkg.sv
hw/fetch/riscv_if.sv
hw/decode/riscv_id.sv
hw/decode/riscv_rf.sv
hw/execute/riscv_alu.sv
hw/execute/riscv_bu.sv
hw/riscv_wb.sv
hw/riscv_core.sv
testbench/riscv_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the riscv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -f riscv_core.f \
  --top-module riscv_core_tb -o riscv_core_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/riscv_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
  exit 1
fi
exit 0

/* testbench/riscv_core_tb.sv */
//////////////////////////////////////////////////
// Random program generated per fetch, data window of
// 64 words at address 0, x1..x31 seeded by ADDI
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none
`include "riscv_config.svh"

module riscv_core_tb;

  // Run length in instructions
  localparam int PROLOGUE = 31;
  localparam int TOTAL    = PROLOGUE + 300;
  localparam int STALL_AT = PROLOGUE + 150;
  localparam int WATCHDOG = TOTAL * 12 + 100;

  // Test ids
  localparam int T_RESET = 0;
  localparam int T_FETCH = 1;
  localparam int T_REGS  = 2;
  localparam int T_MEM   = 3;
  localparam int T_STALL = 4;

  logic                clk = 1'b0;
  logic                rst;
  logic [31:0]         if_parcel;
  logic                if_parcel_valid;
  logic [`RV_XLEN-1:0] dmem_q;
  logic                dmem_ack;
  logic                dbg_stall;
  logic [4:0]          dbg_addr;
  logic [`RV_XLEN-1:0] if_nxt_pc;
  logic                if_req;
  logic [`RV_XLEN-1:0] dmem_adr;
  logic [`RV_XLEN-1:0] dmem_d;
  logic                dmem_we;
  logic                dmem_req;
  logic [`RV_XLEN-1:0] dbg_dato;

  integer seed = 32'hce75_daab;
  string  test_names [5] = '{"reset", "fetch_flow", "registers", "memory", "debug_stall"};
  int     err_cnt [5] = '{default: 0};
  int     chk_cnt [5] = '{default: 0};

  // Reference state
  logic [31:0] m_regs [32];
  logic [31:0] m_pc;
  logic [31:0] ref_mem [64];
  logic [31:0] exp_adr;
  logic [31:0] exp_d;
  logic        exp_we;
  int          mem_issued = 0;
  int          mem_seen;
  int          n_fetch;
  logic        prog_done;

  // Bus side data memory
  logic [31:0] dmem [64];

  riscv_core dut0 (.*);

  always #50 clk = ~clk;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////
  task automatic check_val(input int test_id, input string what,
                           input logic [31:0] exp_v, input logic [31:0] act_v);
    chk_cnt[test_id]++;
    if (act_v !== exp_v)
    begin
      err_cnt[test_id]++;
      $display("error %s %s expected %h actual %h", test_names[test_id], what, exp_v, act_v);
    end
  endtask

  task automatic report_test(input int test_id);
    if (err_cnt[test_id] == 0)
      $display("test %s passed, %0d checks", test_names[test_id], chk_cnt[test_id]);
    else
      $display("test %s failed, %0d of %0d checks wrong", test_names[test_id],
               err_cnt[test_id], chk_cnt[test_id]);
  endtask

  // One cycle with fetch parked
  task automatic stalled_cycle();
    @(negedge clk);
    check_val(T_STALL, "no_fetch_final", '0, 32'(if_req));
  endtask

  function automatic int unsigned rand_range(input int unsigned lo, input int unsigned hi);
    int unsigned r;
    r = $unsigned($random(seed));
    return lo + r % (hi - lo + 1);
  endfunction

  // Scrambled by the whole byte address
  function automatic logic [31:0] fill_word(input int idx);
    logic [31:0] a;
    a = 32'(idx * 4);
    return (a * 32'h9e37_79b9) ^ {a[15:0], ~a[15:0]};
  endfunction

  //////////////////////////////////////////////////
  // Instruction generator
  //////////////////////////////////////////////////
  function automatic logic [31:0] gen_instr(input int idx);
    riscv_pkg::instr_t ins;
    logic [11:0]       w_off;
    logic [12:0]       b_off;
    logic [20:0]       j_off;
    int unsigned       kind;
    ins   = '0;
    // Word aligned, inside the window
    w_off = 12'(rand_range(0, 63) * 4);
    // Short hops either way
    b_off = 13'((int'(rand_range(0, 32)) - 16) * 4);
    j_off = 21'((int'(rand_range(0, 32)) - 16) * 4);
    ins.r.rd  = 5'(rand_range(0, 31));
    ins.r.rs1 = 5'(rand_range(0, 31));
    ins.r.rs2 = 5'(rand_range(0, 31));
    kind = (idx < PROLOGUE) ? 6 : rand_range(0, 15);
    case (kind)
      0, 1, 2, 3, 4, 5:
      begin
        ins.r.opcode = riscv_pkg::opc_op;
        case (kind)
          0, 1:    ins.r.funct3 = 3'b000;
          2:       ins.r.funct3 = 3'b111;
          3:       ins.r.funct3 = 3'b110;
          4:       ins.r.funct3 = 3'b100;
          default: ins.r.funct3 = 3'b010;
        endcase
        ins.r.funct7 = (kind == 1) ? 7'h20 : 7'h00;
      end
      6, 7, 8, 9:
      begin
        ins.i.opcode = riscv_pkg::opc_op_imm;
        ins.i.imm    = 12'(rand_range(0, 4095));
        case (kind)
          6:       ins.i.funct3 = 3'b000;
          7:       ins.i.funct3 = 3'b100;
          8:       ins.i.funct3 = 3'b110;
          default: ins.i.funct3 = 3'b111;
        endcase
      end
      10:
      begin
        ins.u.opcode   = riscv_pkg::opc_lui;
        ins.u.imm31_12 = 20'(rand_range(0, 32'h000f_ffff));
      end
      11:
      begin
        ins.i.opcode = riscv_pkg::opc_load;
        ins.i.funct3 = 3'b010;
        ins.i.rs1    = 5'd0;
        ins.i.imm    = w_off;
      end
      12:
      begin
        ins.s.opcode  = riscv_pkg::opc_store;
        ins.s.funct3  = 3'b010;
        ins.s.rs1     = 5'd0;
        ins.s.imm11_5 = w_off[11:5];
        ins.s.imm4_0  = w_off[4:0];
      end
      13, 14:
      begin
        ins.b.opcode  = riscv_pkg::opc_branch;
        ins.b.funct3  = (kind == 13) ? 3'b000 : 3'b001;
        // Equal operands half the time
        if (rand_range(0, 1) == 1)
          ins.b.rs2 = ins.b.rs1;
        ins.b.imm12   = b_off[12];
        ins.b.imm11   = b_off[11];
        ins.b.imm10_5 = b_off[10:5];
        ins.b.imm4_1  = b_off[4:1];
      end
      default:
      begin
        ins.j.opcode   = riscv_pkg::opc_jal;
        ins.j.imm20    = j_off[20];
        ins.j.imm19_12 = j_off[19:12];
        ins.j.imm11    = j_off[11];
        ins.j.imm10_1  = j_off[10:1];
      end
    endcase
    // Prologue seeds x1..x31 from x0
    if (idx < PROLOGUE)
    begin
      ins.i.rd  = 5'(idx + 1);
      ins.i.rs1 = 5'd0;
    end
    return ins;
  endfunction

  //////////////////////////////////////////////////
  // Reference model, ISA rules on raw bits
  //////////////////////////////////////////////////
  function automatic void ref_exec(input logic [31:0] ins);
    logic [6:0]  opc;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] res;
    logic [31:0] nxt;
    logic        wr;
    opc   = ins[6:0];
    rd    = ins[11:7];
    f3    = ins[14:12];
    rs1   = ins[19:15];
    rs2   = ins[24:20];
    a     = m_regs[rs1];
    b     = m_regs[rs2];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    nxt   = m_pc + 32'd4;
    res   = '0;
    wr    = 1'b0;
    case (opc)
      riscv_pkg::opc_op, riscv_pkg::opc_op_imm:
      begin
        wr = 1'b1;
        // Immediate forms take imm as operand B
        if (opc == riscv_pkg::opc_op_imm)
          b = imm_i;
        case (f3)
          3'b000:
            res = (opc == riscv_pkg::opc_op && ins[30]) ? a - b : a + b;
          3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          3'b100:  res = a ^ b;
          3'b110:  res = a | b;
          3'b111:  res = a & b;
          default: wr = 1'b0;
        endcase
      end
      riscv_pkg::opc_lui:
      begin
        wr  = 1'b1;
        res = {ins[31:12], 12'h000};
      end
      riscv_pkg::opc_load:
      begin
        wr      = 1'b1;
        exp_adr = a + imm_i;
        exp_we  = 1'b0;
        res     = ref_mem[exp_adr[7:2]];
        mem_issued++;
      end
      riscv_pkg::opc_store:
      begin
        exp_adr = a + imm_s;
        exp_we  = 1'b1;
        exp_d   = b;
        ref_mem[exp_adr[7:2]] = b;
        mem_issued++;
      end
      riscv_pkg::opc_branch:
        if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b))
          nxt = m_pc + imm_b;
      riscv_pkg::opc_jal:
      begin
        wr  = 1'b1;
        res = m_pc + 32'd4;
        nxt = m_pc + imm_j;
      end
      default: ;
    endcase
    if (wr && rd != 5'd0)
      m_regs[rd] = res;
    m_pc = nxt;
  endfunction

  //////////////////////////////////////////////////
  // Instruction memory and debug stall
  //////////////////////////////////////////////////
  initial
  begin : imem_model
    logic [31:0] ins;
    int unsigned lat;
    int unsigned hold;
    if_parcel       = '0;
    if_parcel_valid = 1'b0;
    dbg_stall       = 1'b0;
    prog_done       = 1'b0;
    n_fetch         = 0;
    m_pc            = `RV_PC_INIT;
    for (int i = 0; i < 32; i++)
      m_regs[i] = '0;
    for (int i = 0; i < 64; i++)
      ref_mem[i] = fill_word(i);
    while (n_fetch < TOTAL)
    begin
      @(negedge clk);
      if (if_req)
      begin
        check_val(T_FETCH, "fetch_pc", m_pc, if_nxt_pc);
        // Previous access finished before this fetch
        check_val(T_MEM, "access_done", 32'(mem_issued), 32'(mem_seen));
        ins = gen_instr(n_fetch);
        ref_exec(ins);
        n_fetch++;
        lat = rand_range(1, 4);
        repeat (lat - 1) @(negedge clk);
        if_parcel       = ins;
        if_parcel_valid = 1'b1;
        // Stall raised while this one is in flight
        if (n_fetch == STALL_AT || n_fetch == TOTAL)
          dbg_stall = 1'b1;
        @(negedge clk);
        if_parcel_valid = 1'b0;
        if (n_fetch == STALL_AT)
        begin
          hold = rand_range(5, 20);
          repeat (hold)
          begin
            @(negedge clk);
            check_val(T_STALL, "no_fetch", '0, 32'(if_req));
          end
          dbg_stall = 1'b0;
        end
      end
    end
    prog_done = 1'b1;
  end

  //////////////////////////////////////////////////
  // Data memory with random ack delay
  //////////////////////////////////////////////////
  initial
  begin : dmem_model
    logic [31:0] adr_q;
    logic [31:0] d_q;
    logic        we_q;
    int unsigned lat;
    dmem_ack = 1'b0;
    dmem_q   = '0;
    mem_seen = 0;
    for (int i = 0; i < 64; i++)
      dmem[i] = fill_word(i);
    forever
    begin
      @(negedge clk);
      if (dmem_req)
      begin
        check_val(T_MEM, "access_expected", 32'(mem_issued), 32'(mem_seen + 1));
        check_val(T_MEM, "adr", exp_adr, dmem_adr);
        check_val(T_MEM, "we", 32'(exp_we), 32'(dmem_we));
        if (exp_we)
          check_val(T_MEM, "store_data", exp_d, dmem_d);
        adr_q = dmem_adr;
        d_q   = dmem_d;
        we_q  = dmem_we;
        lat   = rand_range(0, 3);
        // Request must hold still under back-pressure
        repeat (lat)
        begin
          @(negedge clk);
          check_val(T_MEM, "req_held", 32'd1, 32'(dmem_req));
          check_val(T_MEM, "adr_stable", adr_q, dmem_adr);
          check_val(T_MEM, "we_stable", 32'(we_q), 32'(dmem_we));
          check_val(T_MEM, "data_stable", d_q, dmem_d);
        end
        if (we_q)
          dmem[adr_q[7:2]] = d_q;
        else
          dmem_q = dmem[adr_q[7:2]];
        dmem_ack = 1'b1;
        mem_seen++;
        @(negedge clk);
        dmem_ack = 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // Reset, end of run and summary
  //////////////////////////////////////////////////
  initial
  begin : main_seq
    int total_err;
    int total_chk;
    rst      = 1'b1;
    dbg_addr = '0;
    repeat (2)
    begin
      @(negedge clk);
      check_val(T_RESET, "if_req_in_reset", '0, 32'(if_req));
      check_val(T_RESET, "dmem_req_in_reset", '0, 32'(dmem_req));
    end
    rst = 1'b0;
    @(negedge clk);
    check_val(T_RESET, "dmem_req_after_reset", '0, 32'(dmem_req));
    check_val(T_RESET, "first_if_req", 32'd1, 32'(if_req));
    check_val(T_RESET, "first_pc", `RV_PC_INIT, if_nxt_pc);
    report_test(T_RESET);

    // Drain the last instruction under stall
    wait (prog_done);
    repeat (3)
      stalled_cycle();
    while (dmem_req)
      stalled_cycle();
    repeat (2)
      stalled_cycle();

    // Registers over the debug port
    for (int i = 0; i < 32; i++)
    begin
      dbg_addr = 5'(i);
      stalled_cycle();
      check_val(T_REGS, $sformatf("x%0d", i), m_regs[i], dbg_dato);
    end
    for (int i = 0; i < 64; i++)
      check_val(T_MEM, $sformatf("window_%0d", i), ref_mem[i], dmem[i]);
    check_val(T_MEM, "access_done", 32'(mem_issued), 32'(mem_seen));

    report_test(T_FETCH);
    report_test(T_REGS);
    report_test(T_MEM);
    report_test(T_STALL);
    total_err = 0;
    total_chk = 0;
    for (int t = 0; t < 5; t++)
    begin
      total_err += err_cnt[t];
      total_chk += chk_cnt[t];
    end
    $display("%0d instructions, %0d checks, %0d errors", n_fetch, total_chk, total_err);
    if (total_err == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

  // Bounded by the worst cycle count per instruction
  initial
  begin : watchdog
    repeat (WATCHDOG) @(posedge clk);
    $display("timeout after %0d cycles, the core stopped fetching", WATCHDOG);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire
